// ==== mctp_egrs_pkg.sv ====
/*
 * MCTP over PCIe VDM egress engine, shared definitions
 * Widths, slave register map, VDM header constants, the message
 * descriptor and the two functions that pack the TLP header beats
 */
`default_nettype none

package mctp_egrs_pkg;

   // -------------------------------------------------------------------
   // Widths and register map
   // -------------------------------------------------------------------
   localparam int SLV_ADDR_W = 9;    // Bit 8 selects the payload buffer
   localparam int BUF_ADDR_W = 8;
   localparam int DW_W       = 32;
   localparam int BEAT_W     = 64;

   localparam logic [SLV_ADDR_W-1:0] CTRL_REG_ADDR = 9'd0;
   localparam logic [SLV_ADDR_W-1:0] HDR_REG_ADDR  = 9'd1;

   // -------------------------------------------------------------------
   // VDM header constants
   // -------------------------------------------------------------------
   localparam logic [3:0]  MCTP_HDR_VERSION = 4'h1;
   localparam logic [7:0]  VDM_MSG_CODE     = 8'h7F;
   localparam logic [15:0] VDM_VENDOR_ID    = 16'h1AB4;  // DMTF
   localparam logic [4:0]  TLP_FMT_TYPE     = 5'h0E;     // Msg with data
   localparam logic [2:0]  ROUTE_RC         = 3'd0;
   localparam logic [2:0]  ROUTE_BY_ID      = 3'd2;

   // Message as latched by the register block
   typedef struct packed {
      logic [8:0]  len_dw;      // 1 to 256 DWORDs
      logic [1:0]  pad;
      logic [15:0] target_id;
      logic [7:0]  dst_eid;
      logic [3:0]  tag;         // TO bit on top
      logic [7:0]  src_eid;
      logic [2:0]  route;
   } msg_desc_t;

   typedef struct packed {
      logic       som;
      logic       eom;
      logic [1:0] seq;
   } tlp_flags_t;

   // First VDM header beat, byte 7 on the left
   function automatic logic [BEAT_W-1:0] build_hdr1(input logic [9:0] len_dw,
                                                     input logic [1:0] pad,
                                                     input logic [2:0] route);
      return {VDM_MSG_CODE,         // Byte 7
              2'b00, pad, 4'h0,     // Byte 6
              16'h0000,             // Bytes 5, 4
              len_dw[7:0],          // Byte 3
              6'd0, len_dw[9:8],    // Byte 2, attributes clear
              8'h00,                // Byte 1
              TLP_FMT_TYPE, route}; // Byte 0
   endfunction

   // Second VDM header beat, MCTP transport header inside
   function automatic logic [BEAT_W-1:0] build_hdr2(input msg_desc_t  desc,
                                                     input tlp_flags_t flags);
      return {flags, desc.tag,                  // Byte 7
              desc.src_eid,                     // Byte 6
              desc.dst_eid,                     // Byte 5
              4'h0, MCTP_HDR_VERSION,           // Byte 4
              VDM_VENDOR_ID[7:0],               // Byte 3
              VDM_VENDOR_ID[15:8],              // Byte 2
              desc.target_id[7:0],              // Byte 1
              desc.target_id[15:8]};            // Byte 0
   endfunction

endpackage

`default_nettype wire

// ==== egrs_msg_if.sv ====
/*
 * Message handoff between the register block and the TLP sender
 * The register block pulses start with a stable descriptor, the
 * sender reports busy and its running sequence number
 */
`default_nettype none

interface egrs_msg_if;

   logic                     start;   // One cycle
   mctp_egrs_pkg::msg_desc_t desc;
   logic                     busy;
   logic [1:0]               seq;

   modport csr_mp (
      output start,
      output desc,
      input  busy
   );

   modport sender_mp (
      input  start,
      input  desc,
      output busy,
      output seq
   );

endinterface

`default_nettype wire

// ==== egrs_csr.sv ====
/*
 * Egress slave write decoder
 * Holds the control and packet header registers, resolves source EID
 * and routing at write time, pulses start and steers buffer writes.
 * All writes are dropped while a message is in flight.
 */
`default_nettype none

module egrs_csr (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    slv_write_i,
   input  logic [mctp_egrs_pkg::SLV_ADDR_W-1:0]    slv_addr_i,
   input  logic [mctp_egrs_pkg::DW_W-1:0]          slv_wdata_i,
   output logic                                    slv_waitreq_o,
   input  logic [7:0]                              local_eid_i,
   egrs_msg_if.csr_mp                              msg,
   output logic                                    buf_wr_en_o,
   output logic [mctp_egrs_pkg::BUF_ADDR_W-1:0]    buf_wr_addr_o,
   output logic [mctp_egrs_pkg::DW_W-1:0]          buf_wr_data_o
);

   logic                     wr_ok;
   logic                     ctrl_wr;
   logic                     hdr_wr;
   mctp_egrs_pkg::msg_desc_t desc_q;

   // Start cycle also locked out so the descriptor stays put
   assign wr_ok   = slv_write_i & ~msg.busy & ~msg.start;
   assign ctrl_wr = wr_ok && (slv_addr_i == mctp_egrs_pkg::CTRL_REG_ADDR);
   assign hdr_wr  = wr_ok && (slv_addr_i == mctp_egrs_pkg::HDR_REG_ADDR);

   // -------------------------------------------------------------------
   // Payload buffer write port
   // -------------------------------------------------------------------
   assign buf_wr_en_o   = wr_ok & slv_addr_i[mctp_egrs_pkg::SLV_ADDR_W-1];
   assign buf_wr_addr_o = slv_addr_i[mctp_egrs_pkg::BUF_ADDR_W-1:0];
   assign buf_wr_data_o = slv_wdata_i;

   assign msg.desc = desc_q;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         slv_waitreq_o <= 1'b1;
         msg.start     <= 1'b0;
      end else begin
         slv_waitreq_o <= 1'b0;
         msg.start     <= ctrl_wr & slv_wdata_i[0];
      end
   end

   // Descriptor fields
   always_ff @(posedge clk) begin
      if (ctrl_wr) begin
         desc_q.len_dw <= slv_wdata_i[14:6];
         desc_q.pad    <= slv_wdata_i[5:4];
      end
      if (hdr_wr) begin
         desc_q.dst_eid <= slv_wdata_i[23:16];
         desc_q.tag     <= slv_wdata_i[27:24];
         // Null source EID
         desc_q.src_eid <= slv_wdata_i[28] ? 8'h00 : local_eid_i;
         // Root complex routing carries no target
         desc_q.target_id <= slv_wdata_i[29] ? slv_wdata_i[15:0] : 16'h0000;
         desc_q.route     <= slv_wdata_i[29] ? mctp_egrs_pkg::ROUTE_BY_ID
                                             : mctp_egrs_pkg::ROUTE_RC;
      end
   end

endmodule

`default_nettype wire

// ==== egrs_buffer.sv ====
/*
 * Egress payload buffer
 * 256 x 32 simple dual-port RAM, registered read address and
 * registered output for two cycles from address to data
 */
`default_nettype none

module egrs_buffer (
   input  logic                                    clk,
   input  logic                                    wr_en_i,
   input  logic [mctp_egrs_pkg::BUF_ADDR_W-1:0]    wr_addr_i,
   input  logic [mctp_egrs_pkg::DW_W-1:0]          wr_data_i,
   input  logic [mctp_egrs_pkg::BUF_ADDR_W-1:0]    rd_addr_i,
   output logic [mctp_egrs_pkg::DW_W-1:0]          rd_data_o
);

   logic [mctp_egrs_pkg::DW_W-1:0]       mem [0:2**mctp_egrs_pkg::BUF_ADDR_W-1];
   logic [mctp_egrs_pkg::BUF_ADDR_W-1:0] rd_addr_q;

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
      rd_addr_q <= rd_addr_i;       // Address stage
      rd_data_o <= mem[rd_addr_q];  // Output stage
   end

endmodule

`default_nettype wire

// ==== egrs_tlp_sender.sv ====
/*
 * Egress TLP sender
 * Splits a message into MTU sized VDM TLPs and writes each one to the
 * AFU as SOP, two header beats, payload beats and EOP. Payload DWORDs
 * are read in pairs, the next beat prefetched while the port stalls.
 */
`default_nettype none

module egrs_tlp_sender #(
   parameter int MTU_DW     = 16,
   parameter int AFU_ADDR_W = 21
) (
   input  logic                                    clk,
   input  logic                                    reset,
   egrs_msg_if.sender_mp                           msg,
   output logic [mctp_egrs_pkg::BUF_ADDR_W-1:0]    buf_rd_addr_o,
   input  logic [mctp_egrs_pkg::DW_W-1:0]          buf_rd_data_i,
   input  logic [AFU_ADDR_W-1:0]                   afu_base_i,
   output logic                                    mst_write_o,
   output logic [AFU_ADDR_W-1:0]                   mst_addr_o,
   output logic [mctp_egrs_pkg::BEAT_W-1:0]        mst_wdata_o,
   output logic [7:0]                              mst_byteen_o,
   input  logic                                    mst_waitreq_i
);

   localparam int LEN_W = $clog2(MTU_DW + 1);

   // One-hot state bit positions
   localparam int S_IDLE  = 0,
                  S_SOP   = 1,
                  S_HDR1  = 2,
                  S_HDR2  = 3,
                  S_PLOAD = 4,
                  S_EOP   = 5;

   logic [5:0]                       state;
   logic [5:0]                       state_nxt;
   logic [5:0]                       state_q;
   logic [8:0]                       pend_len;   // DWORDs not yet sent
   logic                             first;      // First TLP of message
   logic [LEN_W-1:0]                 tlp_len;
   logic                             last_tlp;
   mctp_egrs_pkg::tlp_flags_t        flags;
   logic [LEN_W-1:0]                 rd_left;    // DWORDs left to read
   logic                             second;
   logic                             rv1;
   logic                             rv2;
   logic [1:0]                       tg1;        // {beat done, odd beat}
   logic [1:0]                       tg2;
   logic [mctp_egrs_pkg::DW_W-1:0]   lo_dw;
   logic [mctp_egrs_pkg::BEAT_W-1:0] stg_data;
   logic [7:0]                       stg_be;
   logic                             stg_vld;
   logic                             accept;
   logic                             port_free;
   logic                             issue_lo;
   logic                             issue;
   logic                             pl_done;
   logic                             ctl_load;
   logic                             pl_load;
   logic [mctp_egrs_pkg::BEAT_W-1:0] ctl_beat;
   logic [3:0]                       ctl_off;

   assign msg.busy = ~state[S_IDLE];

   always_comb begin
      tlp_len   = (pend_len > 9'(MTU_DW)) ? LEN_W'(MTU_DW) : LEN_W'(pend_len);
      last_tlp  = (pend_len <= 9'(MTU_DW));
      flags.som = first;
      flags.eom = last_tlp;
      flags.seq = msg.seq;

      accept    = mst_write_o & ~mst_waitreq_i;
      port_free = ~mst_write_o | ~mst_waitreq_i;

      // New pair only once the previous beat has left the stage
      issue_lo = state[S_PLOAD] && (rd_left != '0) && !second && !rv1 && !rv2 &&
                 (!stg_vld || port_free);
      issue    = issue_lo | second;
      pl_done  = (rd_left == '0) && !second && !rv1 && !rv2 && !stg_vld;

      ctl_load = (state != state_q) &&
                 (state[S_SOP] | state[S_HDR1] | state[S_HDR2] | state[S_EOP]);
      pl_load  = state[S_PLOAD] & stg_vld & port_free;

      ctl_off = (state[S_HDR1] | state[S_HDR2]) ? 4'h8 : 4'h0;
      unique case (1'b1)
         state[S_HDR1]: ctl_beat = mctp_egrs_pkg::build_hdr1(10'(tlp_len),
                                      last_tlp ? msg.desc.pad : 2'd0, msg.desc.route);
         state[S_HDR2]: ctl_beat = mctp_egrs_pkg::build_hdr2(msg.desc, flags);
         state[S_EOP]:  ctl_beat = 64'd2;
         default:       ctl_beat = 64'd1;   // SOP
      endcase
   end

   // -------------------------------------------------------------------
   // Next state, advancing on each beat acceptance
   // -------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      unique case (1'b1)
         state[S_IDLE]:  if (msg.start) state_nxt = 6'd1 << S_SOP;
         state[S_SOP]:   if (accept) state_nxt = 6'd1 << S_HDR1;
         state[S_HDR1]:  if (accept) state_nxt = 6'd1 << S_HDR2;
         state[S_HDR2]:  if (accept) state_nxt = 6'd1 << S_PLOAD;
         state[S_PLOAD]: if (accept && pl_done) state_nxt = 6'd1 << S_EOP;
         state[S_EOP]: begin
            if (accept) begin
               state_nxt = last_tlp ? 6'd1 << S_IDLE : 6'd1 << S_SOP;
            end
         end
         default:        state_nxt = 6'd1 << S_IDLE;
      endcase
   end

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state         <= 6'd1 << S_IDLE;
         state_q       <= 6'd1 << S_IDLE;
         pend_len      <= '0;
         first         <= 1'b0;
         msg.seq       <= 2'd0;
         rd_left       <= '0;
         buf_rd_addr_o <= '0;
         second        <= 1'b0;
         rv1           <= 1'b0;
         rv2           <= 1'b0;
         stg_vld       <= 1'b0;
         mst_write_o   <= 1'b0;
      end else begin
         state   <= state_nxt;
         state_q <= state;

         if (state[S_IDLE] && msg.start) begin
            pend_len <= msg.desc.len_dw;
            first    <= 1'b1;
         end else if (state[S_EOP] && accept) begin
            pend_len <= pend_len - 9'(tlp_len);
            first    <= 1'b0;
            msg.seq  <= msg.seq + 2'd1;     // Carries over to next message
         end

         // Read side, buffer address runs across the whole message
         if (state[S_SOP]) begin
            rd_left <= tlp_len;
         end else if (issue) begin
            rd_left <= rd_left - 1'b1;
         end
         if (state[S_IDLE]) begin
            buf_rd_addr_o <= '0;
         end else if (issue) begin
            buf_rd_addr_o <= buf_rd_addr_o + 1'b1;
         end
         second <= issue_lo && (rd_left > LEN_W'(1));
         rv1    <= issue;
         rv2    <= rv1;

         if (rv2 && tg2[1]) begin
            stg_vld <= 1'b1;
         end else if (pl_load) begin
            stg_vld <= 1'b0;
         end

         if (ctl_load || pl_load) begin
            mst_write_o <= 1'b1;
         end else if (!mst_waitreq_i) begin
            mst_write_o <= 1'b0;
         end
      end
   end

   // -------------------------------------------------------------------
   // Beat assembly and master port payload
   // -------------------------------------------------------------------
   always_ff @(posedge clk) begin
      tg1 <= issue_lo ? {2{rd_left == LEN_W'(1)}} : 2'b10;
      tg2 <= tg1;
      if (rv2 && !tg2[1]) begin
         lo_dw <= buf_rd_data_i;            // Even DWORD
      end
      if (rv2 && tg2[1]) begin
         // Odd tail goes out alone with upper half zeroed
         stg_data <= tg2[0] ? {32'h0, buf_rd_data_i} : {buf_rd_data_i, lo_dw};
         stg_be   <= tg2[0] ? 8'h0F : 8'hFF;
      end

      if (ctl_load) begin
         mst_addr_o   <= {afu_base_i[AFU_ADDR_W-1:4], ctl_off};
         mst_wdata_o  <= ctl_beat;
         mst_byteen_o <= 8'hFF;
      end else if (pl_load) begin
         mst_addr_o   <= {afu_base_i[AFU_ADDR_W-1:4], 4'h8};
         mst_wdata_o  <= stg_data;
         mst_byteen_o <= stg_be;
      end
   end

endmodule

`default_nettype wire

// ==== mctp_egrs_top.sv ====
/*
 * MCTP over PCIe VDM egress engine, top level
 * Register block, payload buffer and TLP sender joined to the slave
 * write port and the AFU master write port
 */
`default_nettype none

module mctp_egrs_top #(
   parameter int MTU_DW     = 16,   // Baseline MTU
   parameter int AFU_ADDR_W = 21
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    slv_write_i,
   input  logic [mctp_egrs_pkg::SLV_ADDR_W-1:0]    slv_addr_i,
   input  logic [mctp_egrs_pkg::DW_W-1:0]          slv_wdata_i,
   output logic                                    slv_waitreq_o,
   input  logic [7:0]                              local_eid_i,
   input  logic [AFU_ADDR_W-1:0]                   afu_base_i,
   output logic                                    mst_write_o,
   output logic [AFU_ADDR_W-1:0]                   mst_addr_o,
   output logic [mctp_egrs_pkg::BEAT_W-1:0]        mst_wdata_o,
   output logic [7:0]                              mst_byteen_o,
   input  logic                                    mst_waitreq_i
);

   logic                                 buf_wr_en;
   logic [mctp_egrs_pkg::BUF_ADDR_W-1:0] buf_wr_addr;
   logic [mctp_egrs_pkg::DW_W-1:0]       buf_wr_data;
   logic [mctp_egrs_pkg::BUF_ADDR_W-1:0] buf_rd_addr;
   logic [mctp_egrs_pkg::DW_W-1:0]       buf_rd_data;

   egrs_msg_if msg_if ();

   egrs_csr egrs_csr_inst (
      .clk           (clk),
      .reset         (reset),
      .slv_write_i   (slv_write_i),
      .slv_addr_i    (slv_addr_i),
      .slv_wdata_i   (slv_wdata_i),
      .slv_waitreq_o (slv_waitreq_o),
      .local_eid_i   (local_eid_i),
      .msg           (msg_if.csr_mp),
      .buf_wr_en_o   (buf_wr_en),
      .buf_wr_addr_o (buf_wr_addr),
      .buf_wr_data_o (buf_wr_data)
   );

   egrs_buffer egrs_buffer_inst (
      .clk       (clk),
      .wr_en_i   (buf_wr_en),
      .wr_addr_i (buf_wr_addr),
      .wr_data_i (buf_wr_data),
      .rd_addr_i (buf_rd_addr),
      .rd_data_o (buf_rd_data)
   );

   egrs_tlp_sender #(
      .MTU_DW     (MTU_DW),
      .AFU_ADDR_W (AFU_ADDR_W)
   ) egrs_tlp_sender_inst (
      .clk           (clk),
      .reset         (reset),
      .msg           (msg_if.sender_mp),
      .buf_rd_addr_o (buf_rd_addr),
      .buf_rd_data_i (buf_rd_data),
      .afu_base_i    (afu_base_i),
      .mst_write_o   (mst_write_o),
      .mst_addr_o    (mst_addr_o),
      .mst_wdata_o   (mst_wdata_o),
      .mst_byteen_o  (mst_byteen_o),
      .mst_waitreq_i (mst_waitreq_i)
   );

endmodule

`default_nettype wire

// ==== tb_egrs_ref.svh ====
/*
 * Reference model for the egress engine testbench
 * Builds the expected master write beats of one message from the VDM
 * header layout and the segmentation rules, plus the LCG
 */
`ifndef TB_EGRS_REF_SVH
`define TB_EGRS_REF_SVH

// Numerical Recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic void queue_beat(input logic [20:0] addr, input logic [63:0] data,
                                   input logic [7:0] be);
   beat_t b;
   b.addr = addr;
   b.data = data;
   b.be   = be;
   exp_q.push_back(b);
endfunction

// Payload comes from the testbench copy of the buffer, returns TLP count
function automatic int build_expected(input int len, input logic [1:0] pad,
                                      input logic [15:0] tid, input logic [7:0] dst,
                                      input logic [3:0] tag, input logic [7:0] src,
                                      input logic by_id, input logic [1:0] seq,
                                      input int mtu, input logic [20:0] base);
   int          pend;
   int          tlen;
   int          idx;
   int          n;
   logic [9:0]  lw;
   logic [1:0]  sq;
   logic [1:0]  p;
   logic        last;
   logic [15:0] t;
   logic [2:0]  rt;
   logic [20:0] a0;
   logic [20:0] a8;
   logic [63:0] h1;
   logic [63:0] h2;
   a0   = {base[20:4], 4'h0};
   a8   = {base[20:4], 4'h8};
   t    = by_id ? tid : 16'h0000;  // RC routing drops the target
   rt   = by_id ? 3'd2 : 3'd0;
   pend = len;
   idx  = 0;
   n    = 0;
   while (pend > 0) begin
      tlen = (pend > mtu) ? mtu : pend;
      last = (pend <= mtu);
      lw   = 10'(tlen);
      sq   = seq + 2'(n);
      p    = last ? pad : 2'd0;   // Pad only on the last TLP
      h1   = {8'h7F, 2'b00, p, 4'h0, 16'h0000, lw[7:0], 6'd0, lw[9:8], 8'h00, 5'h0E, rt};
      h2   = {(n == 0), last, sq, tag, src, dst, 8'h01, 8'hB4, 8'h1A, t[7:0], t[15:8]};
      queue_beat(a0, 64'd1, 8'hFF);
      queue_beat(a8, h1, 8'hFF);
      queue_beat(a8, h2, 8'hFF);
      for (int k = 0; k < tlen; k += 2) begin
         if (k + 1 < tlen) begin
            queue_beat(a8, {payload[idx+k+1], payload[idx+k]}, 8'hFF);
         end else begin
            queue_beat(a8, {32'h0, payload[idx+k]}, 8'h0F);   // Odd tail
         end
      end
      queue_beat(a0, 64'd2, 8'hFF);
      idx  += tlen;
      pend -= tlen;
      n++;
   end
   return n;
endfunction

`endif

// ==== tb_mctp_egrs.sv ====
/*
 * Testbench for the MCTP over PCIe VDM egress engine
 * Loads messages through the slave port, stalls the master port at
 * random and checks every accepted beat against the reference model
 */
`default_nettype none

module tb_mctp_egrs;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int                    MTU_DW     = 16;
   localparam int                    AFU_ADDR_W = 21;
   localparam logic [7:0]            LOCAL_EID  = 8'h5A;
   localparam logic [AFU_ADDR_W-1:0] AFU_BASE   = 21'h12_3450;
   localparam logic [31:0]           SEED       = 32'hcaf0_29d5;

   typedef struct packed {
      logic [AFU_ADDR_W-1:0] addr;
      logic [63:0]           data;
      logic [7:0]            be;
   } beat_t;

   logic                  clk;
   logic                  reset;
   logic                  slv_write_i;
   logic [8:0]            slv_addr_i;
   logic [31:0]           slv_wdata_i;
   logic                  slv_waitreq_o;
   logic [7:0]            local_eid_i;
   logic [AFU_ADDR_W-1:0] afu_base_i;
   logic                  mst_write_o;
   logic [AFU_ADDR_W-1:0] mst_addr_o;
   logic [63:0]           mst_wdata_o;
   logic [7:0]            mst_byteen_o;
   logic                  mst_waitreq_i;

   beat_t       exp_q[$];
   beat_t       got_beat;
   logic [31:0] payload [0:255];   // Mirror of the DUT buffer
   logic [31:0] wait_rnd;
   logic [31:0] data_rnd;
   logic [1:0]  seq_model;
   int          errors;
   int          checks;

   `include "tb_egrs_ref.svh"

   mctp_egrs_top #(
      .MTU_DW     (MTU_DW),
      .AFU_ADDR_W (AFU_ADDR_W)
   ) mctp_egrs_top_inst (
      .clk           (clk),
      .reset         (reset),
      .slv_write_i   (slv_write_i),
      .slv_addr_i    (slv_addr_i),
      .slv_wdata_i   (slv_wdata_i),
      .slv_waitreq_o (slv_waitreq_o),
      .local_eid_i   (local_eid_i),
      .afu_base_i    (afu_base_i),
      .mst_write_o   (mst_write_o),
      .mst_addr_o    (mst_addr_o),
      .mst_wdata_o   (mst_wdata_o),
      .mst_byteen_o  (mst_byteen_o),
      .mst_waitreq_i (mst_waitreq_i)
   );

   always #4 clk = ~clk;

   // AFU back-pressure on about 30% of cycles
   always @(posedge clk) begin
      wait_rnd = lcg_next(wait_rnd);
      mst_waitreq_i <= (wait_rnd[31:24] < 8'd77);
   end

   // -------------------------------------------------------------------
   // Beat monitor and compare
   // -------------------------------------------------------------------
   always @(posedge clk) begin
      if (!reset && mst_write_o && !mst_waitreq_i) begin
         got_beat = {mst_addr_o, mst_wdata_o, mst_byteen_o};
         assert (exp_q.size() != 0) else begin
            errors++;
            $display("Unexpected beat on the master port at %0d ns", $time);
         end
         if (exp_q.size() != 0) begin
            checks++;
            assert (got_beat == exp_q[0]) else begin
               errors++;
               $display("ERROR at %0d ns: got %h %h %h, expected %h %h %h", $time,
                        got_beat.addr, got_beat.data, got_beat.be,
                        exp_q[0].addr, exp_q[0].data, exp_q[0].be);
            end
            void'(exp_q.pop_front());
         end
      end
   end

   task automatic slv_write(input logic [8:0] addr, input logic [31:0] data);
      @(posedge clk);
      slv_write_i <= 1'b1;
      slv_addr_i  <= addr;
      slv_wdata_i <= data;
      @(posedge clk);
      slv_write_i <= 1'b0;
   endtask

   task automatic wait_msg_done(input int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("Timed out with %0d beats of the message still missing", exp_q.size());
         exp_q.delete();
      end
      repeat (3) @(posedge clk);   // Room for stray extra beats
   endtask

   // Load and start one message and optionally write while it is sent
   task automatic send_msg(input int len, input logic [1:0] pad, input logic [15:0] tid,
                           input logic [7:0] dst, input logic [3:0] tag,
                           input logic null_eid, input logic by_id, input logic meddle);
      int tlps;
      for (int i = 0; i < len; i++) begin
         data_rnd   = lcg_next(data_rnd);
         payload[i] = data_rnd;
         slv_write(9'h100 | 9'(i), payload[i]);
      end
      slv_write(mctp_egrs_pkg::HDR_REG_ADDR, {2'b00, by_id, null_eid, tag, dst, tid});
      tlps = build_expected(len, pad, tid, dst, tag, null_eid ? 8'h00 : LOCAL_EID, by_id,
                            seq_model, MTU_DW, AFU_BASE);
      seq_model = seq_model + 2'(tlps);
      slv_write(mctp_egrs_pkg::CTRL_REG_ADDR, {17'd0, 9'(len), pad, 3'b000, 1'b1});
      if (meddle) begin
         for (int i = 0; i < 4; i++) begin
            slv_write(9'h100 | 9'(i), ~payload[i]);
         end
         slv_write(mctp_egrs_pkg::HDR_REG_ADDR, 32'h0);
         slv_write(mctp_egrs_pkg::CTRL_REG_ADDR, {17'd0, 9'd3, 2'd0, 3'b000, 1'b1});
      end
      wait_msg_done(5000);
   endtask

   // -------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------
   initial begin
      int n;
      int len;
      clk           = 1'b0;
      reset         = 1'b1;
      slv_write_i   = 1'b0;
      slv_addr_i    = '0;
      slv_wdata_i   = '0;
      local_eid_i   = LOCAL_EID;
      afu_base_i    = AFU_BASE;
      mst_waitreq_i = 1'b0;
      wait_rnd      = SEED;
      data_rnd      = lcg_next(SEED);
      seq_model     = 2'd0;
      errors        = 0;
      checks        = 0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      n = 0;
      while (slv_waitreq_o && n < 10) begin
         @(posedge clk);
         n++;
      end
      if (slv_waitreq_o) begin
         errors++;
         $display("Slave port still in wait state after reset");
      end

      send_msg(5, 2'd3, 16'h1234, 8'h20, 4'hA, 1'b0, 1'b0, 1'b0);   // Single TLP to the RC
      send_msg(40, 2'd2, 16'h0102, 8'h31, 4'h9, 1'b1, 1'b1, 1'b0);  // Three TLPs with null EID
      send_msg(33, 2'd1, 16'hBEEF, 8'h44, 4'h3, 1'b0, 1'b1, 1'b1);  // Writes while busy

      // Back to back messages and the last one fills the buffer
      for (int m = 0; m < 3; m++) begin
         data_rnd = lcg_next(data_rnd);
         len = (m == 2) ? 256 : int'(data_rnd[31:24]) % 100 + 1;
         send_msg(len, data_rnd[5:4], data_rnd[23:8], data_rnd[15:8], data_rnd[3:0],
                  data_rnd[6], data_rnd[7], 1'b0);
      end

      $display("Beats checked: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
mctp_egrs_pkg.sv
egrs_msg_if.sv
egrs_csr.sv
egrs_buffer.sv
egrs_tlp_sender.sv
mctp_egrs_top.sv
tb_mctp_egrs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the egress engine testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_mctp_egrs -f compile.f -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || echo "Build or simulation run did not complete"

grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }
